/* src/irq_pkg.sv */
// *************************************************
// irq_pkg
// shared sizes, command and report encodings and
// bus structs of the interrupt unit
// *************************************************

package irq_pkg;

	// line counts
	localparam int N_LINES = 32;
	localparam int N_MASK = 10;

	// external sources occupy lines 0..11
	localparam int N_EXT = 12;

	// channel reports occupy lines 12..27
	localparam int N_CHAN = 16;

	// fixed line numbers
	localparam int LINE_CHAN_SPECIAL = 29;
	localparam int LINE_SOFT_LO = 30;
	localparam int LINE_SOFT_HI = 31;

	// sender credits after reset, same as receiver buffer depth
	localparam int CHAN_CREDITS = 2;

	// cpu command opcodes
	typedef enum logic [2:0] {
		CMD_NONE     = 3'd0,
		CMD_SET_MASK = 3'd1,
		CMD_WRITE_RZ = 3'd2,
		CMD_CLEAR_RZ = 3'd3,
		CMD_SOFT_INT = 3'd4,
		CMD_ACK      = 3'd5,
		CMD_RETURN   = 3'd6
	} int_cmd_e;

	// kind of an i/o channel report
	typedef enum logic {
		REP_NORMAL  = 1'b0,
		REP_SPECIAL = 1'b1
	} chan_rep_kind_e;

	// command port, one command per cycle
	typedef struct packed {
		int_cmd_e op;
		logic [15:0] data;
	} int_cmd_t;

	// channel report, valid only while a credit is held
	typedef struct packed {
		logic valid;
		chan_rep_kind_e kind;
		logic [$clog2(N_CHAN)-1:0] chan;
	} chan_rep_t;

	// vector output, valid for one cycle per accepted interrupt
	typedef struct packed {
		logic valid;
		logic [$clog2(N_LINES)-1:0] num;
	} vec_t;

endpackage

/* src/int_mask_reg.sv */
// *************************************************
// int_mask_reg
// 10-bit interrupt mask register, expanded to the
// per-line enables through the fixed group map
// *************************************************

`timescale 1ns/1ps

module int_mask_reg import irq_pkg::*; (
	input logic clk,
	input logic rst,
	input int_cmd_t cmd,
	output logic [N_LINES-1:0] line_en
);

	logic [N_MASK-1:0] mask;

	// mask load from the low data bits
	always_ff @(posedge clk) begin
		if (rst) begin
			mask <= '0;
		end else if (cmd.op == CMD_SET_MASK) begin
			mask <= cmd.data[N_MASK-1:0];
		end
	end

	// group map, line 0 first
	// line 0 cannot be masked
	// lines 1..4 have a bit each
	// the rest share one bit per group
	always_comb begin
		line_en = '0;
		line_en[0] = 1'b1;
		line_en[4:1] = mask[3:0];
		line_en[11:5] = {7{mask[4]}};
		line_en[13:12] = {2{mask[5]}};
		line_en[15:14] = {2{mask[6]}};
		line_en[21:16] = {6{mask[7]}};
		line_en[27:22] = {6{mask[8]}};
		// software, special channel and spare lines
		line_en[31:28] = {4{mask[9]}};
	end

endmodule

/* src/int_request_reg.sv */
// *************************************************
// int_request_reg
// request and in-service registers, fixed priority
// chain from line 0 up, irq and ack selection
// *************************************************

`timescale 1ns/1ps

module int_request_reg import irq_pkg::*; (
	input logic clk,
	input logic rst,
	input int_cmd_t cmd,
	input logic [N_EXT-1:0] ext_int,
	input logic [N_LINES-1:0] chan_set,
	input logic [N_LINES-1:0] line_en,
	output logic irq,
	output logic [N_LINES-1:0] accept_onehot
);

	logic [N_LINES-1:0] req;
	logic [N_LINES-1:0] isr;
	logic [N_LINES-1:0] blocked;
	logic [N_LINES-1:0] eligible;
	logic [N_LINES-1:0] ack_sel;
	logic [N_LINES-1:0] ret_sel;
	logic [N_LINES-1:0] req_set;
	logic [N_LINES-1:0] req_clr;
	logic [N_LINES-1:0] req_next;
	logic [N_LINES-1:0] isr_next;
	logic blk;

	// isolates the lowest set bit, i.e. the highest priority line
	function automatic logic [N_LINES-1:0] lowest_one(input logic [N_LINES-1:0] v);
		return v & (~v + 1'b1);
	endfunction

	// an in-service line blocks itself and everything above it
	always_comb begin
		blk = 1'b0;
		for (int i = 0; i < N_LINES; i++) begin
			blk = blk | isr[i];
			blocked[i] = blk;
		end
	end

	assign eligible = req & line_en & ~blocked;
	assign ack_sel = lowest_one(eligible);
	assign ret_sel = lowest_one(isr);

	// set and clear sources
	always_comb begin
		req_set = '0;
		req_set[N_EXT-1:0] = ext_int;
		req_set = req_set | chan_set;
		req_clr = '0;
		isr_next = isr;
		case (cmd.op)
			CMD_WRITE_RZ: begin
				req_set[N_EXT-1:0] = req_set[N_EXT-1:0] | cmd.data[N_EXT-1:0];
				// upper data nibble goes to lines 28..31
				req_set[31:28] = req_set[31:28] | cmd.data[15:12];
			end
			CMD_CLEAR_RZ: begin
				req_clr = '1;
			end
			CMD_SOFT_INT: begin
				if (cmd.data[0]) begin
					req_set[LINE_SOFT_HI] = 1'b1;
				end else begin
					req_set[LINE_SOFT_LO] = 1'b1;
				end
			end
			CMD_ACK: begin
				// accepted line moves from request to in-service
				req_clr = ack_sel;
				isr_next = isr | ack_sel;
			end
			CMD_RETURN: begin
				isr_next = isr & ~ret_sel;
			end
			default: begin
			end
		endcase
	end

	// clear first, then set
	assign req_next = (req & ~req_clr) | req_set;

	always_ff @(posedge clk) begin
		if (rst) begin
			req <= '0;
			isr <= '0;
			irq <= 1'b0;
			accept_onehot <= '0;
		end else begin
			req <= req_next;
			isr <= isr_next;
			irq <= |eligible;
			// one-cycle accept pulse, zero when nothing was eligible
			if (cmd.op == CMD_ACK) begin
				accept_onehot <= ack_sel;
			end else begin
				accept_onehot <= '0;
			end
		end
	end

endmodule

/* src/int_vector_enc.sv */
// *************************************************
// int_vector_enc
// encodes the accepted line into a registered
// one-cycle vector number
// *************************************************

`timescale 1ns/1ps

module int_vector_enc import irq_pkg::*; (
	input logic clk,
	input logic rst,
	input logic [N_LINES-1:0] accept_onehot,
	output vec_t vec
);

	logic [$clog2(N_LINES)-1:0] num;
	logic any;

	// scan downwards so the lowest set line wins
	always_comb begin
		num = '0;
		for (int i = N_LINES - 1; i >= 0; i--) begin
			if (accept_onehot[i]) begin
				num = ($clog2(N_LINES))'(i);
			end
		end
	end

	assign any = |accept_onehot;

	always_ff @(posedge clk) begin
		if (rst) begin
			vec <= '0;
		end else begin
			vec.valid <= any;
			// number is held only with a valid accept
			if (any) begin
				vec.num <= num;
			end
		end
	end

endmodule

/* src/chan_int_rx.sv */
// *************************************************
// chan_int_rx
// credit-based receiver for i/o channel reports,
// 2-entry buffer and decoding into request lines
// *************************************************

`timescale 1ns/1ps

module chan_int_rx import irq_pkg::*; (
	input logic clk,
	input logic rst,
	input chan_rep_t chan_rep,
	output logic credit_ret,
	output logic [N_LINES-1:0] chan_set
);

	chan_rep_t fifo_q [CHAN_CREDITS];
	chan_rep_t head;
	logic [$clog2(CHAN_CREDITS)-1:0] wr_ptr;
	logic [$clog2(CHAN_CREDITS)-1:0] rd_ptr;
	logic [$clog2(CHAN_CREDITS+1)-1:0] cnt;
	// credits the sender currently holds
	logic [$clog2(CHAN_CREDITS+1)-1:0] cred;
	logic push;
	logic pop;

	// a report without a credit is dropped
	assign push = chan_rep.valid && (cred != '0);
	assign pop = (cnt != '0);
	assign head = fifo_q[rd_ptr];

	// oldest entry decoded to a one-hot line
	always_comb begin
		chan_set = '0;
		if (pop) begin
			if (head.kind == REP_SPECIAL) begin
				chan_set[LINE_CHAN_SPECIAL] = 1'b1;
			end else begin
				chan_set[N_EXT + int'(head.chan)] = 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (push) begin
			fifo_q[wr_ptr] <= chan_rep;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			cnt <= '0;
			cred <= ($bits(cred))'(CHAN_CREDITS);
			credit_ret <= 1'b0;
		end else begin
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			// fill level and sender credits move in opposite directions
			if (push && !pop) begin
				cnt <= cnt + 1'b1;
				cred <= cred - 1'b1;
			end else if (!push && pop) begin
				cnt <= cnt - 1'b1;
				cred <= cred + 1'b1;
			end
			credit_ret <= pop;
		end
	end

endmodule

/* src/int_unit.sv */
// *************************************************
// int_unit
// interrupt unit top: mask, request and in-service
// registers, channel receiver, vector encoder
// *************************************************

`timescale 1ns/1ps

module int_unit import irq_pkg::*; (
	input logic clk,
	input logic rst,
	input int_cmd_t cmd,
	input logic [N_EXT-1:0] ext_int,
	input chan_rep_t chan_rep,
	output logic credit_ret,
	output logic irq,
	output vec_t vec
);

	logic [N_LINES-1:0] line_en;
	logic [N_LINES-1:0] chan_set;
	logic [N_LINES-1:0] accept_onehot;

	// mask and line enables
	int_mask_reg u_mask (
		.clk     (clk),
		.rst     (rst),
		.cmd     (cmd),
		.line_en (line_en)
	);

	// channel reports into one-hot line sets
	chan_int_rx u_chan_rx (
		.clk        (clk),
		.rst        (rst),
		.chan_rep   (chan_rep),
		.credit_ret (credit_ret),
		.chan_set   (chan_set)
	);

	// request, in-service and priority
	int_request_reg u_req (
		.clk           (clk),
		.rst           (rst),
		.cmd           (cmd),
		.ext_int       (ext_int),
		.chan_set      (chan_set),
		.line_en       (line_en),
		.irq           (irq),
		.accept_onehot (accept_onehot)
	);

	// vector number of the accepted line
	int_vector_enc u_vec (
		.clk           (clk),
		.rst           (rst),
		.accept_onehot (accept_onehot),
		.vec           (vec)
	);

endmodule

/* tests/int_unit_tb.sv */
// *************************************************
// int_unit_tb
// table-driven testbench for the interrupt unit
// covering masking, priority, in-service, channel
// credits, software interrupts and register commands
// *************************************************

`timescale 1ns/1ps

module int_unit_tb import irq_pkg::*; ();

	typedef struct {
		string name;
		int_cmd_t cmd;
		logic [N_EXT-1:0] ext;
		chan_rep_t rep;
		int idle;
		logic exp_irq;
		vec_t exp_vec;
	} step_t;

	logic clk;
	logic rst;
	int_cmd_t cmd;
	logic [N_EXT-1:0] ext_int;
	chan_rep_t chan_rep;
	logic credit_ret;
	logic irq;
	vec_t vec;

	step_t steps[$];
	// credits held by the modelled channel sender
	int credits = CHAN_CREDITS;
	int cycle_cnt = 0;
	int cycle_limit = 0;

	int_unit DUT (
		.clk        (clk),
		.rst        (rst),
		.cmd        (cmd),
		.ext_int    (ext_int),
		.chan_rep   (chan_rep),
		.credit_ret (credit_ret),
		.irq        (irq),
		.vec        (vec)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	task automatic report_fail(input string msg);
		$display("%s", msg);
		$display("test failed");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic check_irq(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			report_fail($sformatf("CHECK FAILED %s irq expected %0b actual %0b",
				name, exp, act));
		end
	endtask

	task automatic check_vec(input string name, input vec_t exp, input vec_t act);
		// num is only meaningful with valid set
		if (act.valid !== exp.valid || (exp.valid && act.num !== exp.num)) begin
			report_fail($sformatf("CHECK FAILED %s vec expected %0b/%0d actual %0b/%0d",
				name, exp.valid, exp.num, act.valid, act.num));
		end
	endtask

	task automatic check_credit(input string name, input int exp, input int act);
		if (act != exp) begin
			report_fail($sformatf("CHECK FAILED %s credits expected %0d actual %0d",
				name, exp, act));
		end
	endtask

	function automatic chan_rep_t no_rep();
		chan_rep_t r;
		r = '0;
		return r;
	endfunction

	function automatic chan_rep_t rep_normal(input int ch);
		chan_rep_t r;
		r.valid = 1'b1;
		r.kind = REP_NORMAL;
		r.chan = 4'(ch);
		return r;
	endfunction

	function automatic chan_rep_t rep_special();
		chan_rep_t r;
		r.valid = 1'b1;
		r.kind = REP_SPECIAL;
		r.chan = 4'd0;
		return r;
	endfunction

	function automatic vec_t no_vec();
		vec_t v;
		v = '0;
		return v;
	endfunction

	function automatic vec_t vec_line(input int n);
		vec_t v;
		v.valid = 1'b1;
		v.num = 5'(n);
		return v;
	endfunction

	function automatic void add_step(input string name, input int_cmd_e op,
		input logic [15:0] data, input logic [N_EXT-1:0] ext, input chan_rep_t rep,
		input int idle, input logic exp_irq, input vec_t exp_vec);
		step_t s;
		s.name = name;
		s.cmd.op = op;
		s.cmd.data = data;
		s.ext = ext;
		s.rep = rep;
		s.idle = idle;
		s.exp_irq = exp_irq;
		s.exp_vec = exp_vec;
		steps.push_back(s);
	endfunction

	// advance to the next falling edge and count returned credits
	task automatic next_cycle();
		@(negedge clk);
		if (credit_ret === 1'b1) begin
			credits++;
		end
	endtask

	always @(posedge clk) begin
		cycle_cnt++;
		if (cycle_limit > 0 && cycle_cnt > cycle_limit) begin
			report_fail($sformatf("timeout: run exceeded %0d cycles", cycle_limit));
		end
	end

	initial begin
		int ch_a;
		int ch_b;
		int lo;
		int hi;
		void'($urandom(49));
		rst = 1'b1;
		cmd = '{op: CMD_NONE, data: 16'h0000};
		ext_int = '0;
		chan_rep = no_rep();

		// two distinct random channels
		ch_a = int'($urandom % N_CHAN);
		ch_b = int'((ch_a + 1 + $urandom % (N_CHAN - 1)) % N_CHAN);
		lo = N_EXT + ((ch_a < ch_b) ? ch_a : ch_b);
		hi = N_EXT + ((ch_a < ch_b) ? ch_b : ch_a);

		add_step("line0 raise", CMD_NONE, 16'h0000, 12'h001, no_rep(), 1, 1'b1, no_vec());
		add_step("line0 ack", CMD_ACK, 16'h0000, 12'h000, no_rep(), 1, 1'b0, vec_line(0));
		add_step("line0 return", CMD_RETURN, 16'h0000, 12'h000, no_rep(), 1, 1'b0, no_vec());
		add_step("line5 masked", CMD_NONE, 16'h0000, 12'h020, no_rep(), 1, 1'b0, no_vec());
		add_step("mask grp4", CMD_SET_MASK, 16'h0010, 12'h000, no_rep(), 1, 1'b1, no_vec());
		add_step("line5 ack", CMD_ACK, 16'h0000, 12'h000, no_rep(), 1, 1'b0, vec_line(5));
		add_step("line5 return", CMD_RETURN, 16'h0000, 12'h000, no_rep(), 1, 1'b0, no_vec());
		add_step("mask l3 l7", CMD_SET_MASK, 16'h0014, 12'h000, no_rep(), 0, 1'b0, no_vec());
		add_step("lines 3 7", CMD_NONE, 16'h0000, 12'h088, no_rep(), 1, 1'b1, no_vec());
		add_step("ack 3", CMD_ACK, 16'h0000, 12'h000, no_rep(), 1, 1'b0, vec_line(3));
		add_step("hold 3", CMD_NONE, 16'h0000, 12'h000, no_rep(), 1, 1'b0, no_vec());
		add_step("return 3", CMD_RETURN, 16'h0000, 12'h000, no_rep(), 1, 1'b1, no_vec());
		add_step("ack 7", CMD_ACK, 16'h0000, 12'h000, no_rep(), 1, 1'b0, vec_line(7));
		add_step("return 7", CMD_RETURN, 16'h0000, 12'h000, no_rep(), 1, 1'b0, no_vec());
		add_step("mask chan", CMD_SET_MASK, 16'h03e0, 12'h000, no_rep(), 0, 1'b0, no_vec());
		// back-to-back reports drain on two consecutive edges
		add_step("rep a", CMD_NONE, 16'h0000, 12'h000, rep_normal(ch_a), 0, 1'b0, no_vec());
		add_step("rep b", CMD_NONE, 16'h0000, 12'h000, rep_normal(ch_b), 2, 1'b1, no_vec());
		add_step("ack chan lo", CMD_ACK, 16'h0000, 12'h000, no_rep(), 1, 1'b0, vec_line(lo));
		add_step("ret chan lo", CMD_RETURN, 16'h0000, 12'h000, no_rep(), 1, 1'b1, no_vec());
		add_step("ack chan hi", CMD_ACK, 16'h0000, 12'h000, no_rep(), 1, 1'b0, vec_line(hi));
		add_step("ret chan hi", CMD_RETURN, 16'h0000, 12'h000, no_rep(), 1, 1'b0, no_vec());
		add_step("rep special", CMD_NONE, 16'h0000, 12'h000, rep_special(), 2, 1'b1, no_vec());
		add_step("ack special", CMD_ACK, 16'h0000, 12'h000, no_rep(), 1, 1'b0,
			vec_line(LINE_CHAN_SPECIAL));
		add_step("ret special", CMD_RETURN, 16'h0000, 12'h000, no_rep(), 1, 1'b0, no_vec());
		add_step("soft lo", CMD_SOFT_INT, 16'h0000, 12'h000, no_rep(), 1, 1'b1, no_vec());
		add_step("ack soft lo", CMD_ACK, 16'h0000, 12'h000, no_rep(), 1, 1'b0,
			vec_line(LINE_SOFT_LO));
		add_step("ret soft lo", CMD_RETURN, 16'h0000, 12'h000, no_rep(), 1, 1'b0, no_vec());
		add_step("soft hi", CMD_SOFT_INT, 16'h0001, 12'h000, no_rep(), 1, 1'b1, no_vec());
		add_step("ack soft hi", CMD_ACK, 16'h0000, 12'h000, no_rep(), 1, 1'b0,
			vec_line(LINE_SOFT_HI));
		add_step("ret soft hi", CMD_RETURN, 16'h0000, 12'h000, no_rep(), 1, 1'b0, no_vec());
		// lines 2 and 28 with only 28 enabled so far
		add_step("write rz", CMD_WRITE_RZ, 16'h1004, 12'h000, no_rep(), 1, 1'b1, no_vec());
		add_step("ack rz 28", CMD_ACK, 16'h0000, 12'h000, no_rep(), 1, 1'b0, vec_line(28));
		add_step("ret rz 28", CMD_RETURN, 16'h0000, 12'h000, no_rep(), 1, 1'b0, no_vec());
		add_step("mask grp1", CMD_SET_MASK, 16'h0002, 12'h000, no_rep(), 1, 1'b1, no_vec());
		add_step("clear rz", CMD_CLEAR_RZ, 16'h0000, 12'h000, no_rep(), 1, 1'b0, no_vec());
		add_step("ack empty", CMD_ACK, 16'h0000, 12'h000, no_rep(), 1, 1'b0, no_vec());

		cycle_limit = 50;
		foreach (steps[i]) begin
			cycle_limit += steps[i].idle + 1;
		end

		repeat (4) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		next_cycle();
		check_irq("reset", 1'b0, irq);
		check_vec("reset", no_vec(), vec);
		check_credit("reset", CHAN_CREDITS, credits);

		foreach (steps[i]) begin
			cmd = steps[i].cmd;
			ext_int = steps[i].ext;
			chan_rep = steps[i].rep;
			if (steps[i].rep.valid) begin
				if (credits <= 0) begin
					report_fail($sformatf("step %s sends a report with no credit left",
						steps[i].name));
				end
				credits--;
			end
			next_cycle();
			cmd = '{op: CMD_NONE, data: 16'h0000};
			ext_int = '0;
			chan_rep = no_rep();
			repeat (steps[i].idle) next_cycle();
			check_irq(steps[i].name, steps[i].exp_irq, irq);
			check_vec(steps[i].name, steps[i].exp_vec, vec);
			// a burst ends when the next step carries no report
			if (i + 1 >= steps.size() || !steps[i + 1].rep.valid) begin
				check_credit(steps[i].name, CHAN_CREDITS, credits);
			end
		end

		$display("test passed");
		$finish;
	end

endmodule

/* files.f */
src/irq_pkg.sv
src/int_mask_reg.sv
src/int_request_reg.sv
src/int_vector_enc.sv
src/chan_int_rx.sv
src/int_unit.sv
tests/int_unit_tb.sv

/* Makefile */
TOP = int_unit_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the testbench with Verilator"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing -Wno-fatal -f files.f --top-module $(TOP) -Mdir obj_dir
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "test passed"

clean:
	rm -rf obj_dir
